//--- Makefile
SRCS := $(wildcard hdl/*.sv) $(wildcard verif/*.sv)

.PHONY: run clean

obj_dir/Vtb_boot: $(SRCS) verilog.f
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_boot -o Vtb_boot

run: obj_dir/Vtb_boot
	@out="$$(./obj_dir/Vtb_boot)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^All tests passed"

clean:
	rm -rf obj_dir

//--- hdl/boot_pkg.sv
package boot_pkg;

    // shared system bus
    localparam int BUS_AW = 32;
    localparam int BUS_DW = 32;

    // serial port register map, one word each
    localparam logic [BUS_AW-1:0] SPART_TX_ADDR = 32'h0000_001C;
    localparam logic [BUS_AW-1:0] SPART_RX_ADDR = 32'h0000_001D;

    localparam logic [7:0] BANNER_CHAR = 8'h42;  // 'B'

    // boot sequence
    // banner -> count (4 bytes) -> load (4 bytes per word) -> done
    typedef enum logic [1:0] {
        BOOT_BANNER,
        BOOT_COUNT,
        BOOT_LOAD,
        BOOT_DONE
    } boot_state_t;

endpackage

//--- hdl/boot_top.sv
`timescale 1ns/1ps

module boot_top import boot_pkg::*; #(
    parameter int IMEM_AW       = 14,
    parameter int RX_FIFO_DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    // serial byte stream
    input  logic               rx_valid_i,
    input  logic [7:0]         rx_byte_i,
    output logic               tx_valid_o,
    output logic [7:0]         tx_byte_o,
    // processor data port
    input  logic               cpu_req_i,
    input  logic               cpu_write_i,
    input  logic [BUS_AW-1:0]  cpu_addr_i,
    input  logic [BUS_DW-1:0]  cpu_wdata_i,
    output logic [BUS_DW-1:0]  cpu_rdata_o,
    output logic               cpu_ack_o,
    // instruction fetch
    input  logic [IMEM_AW-1:0] fetch_addr_i,
    output logic [31:0]        fetch_data_o,
    output logic               boot_done_o
);

    sys_bus_if boot_bus ();
    sys_bus_if cpu_bus ();
    sys_bus_if slave_bus ();

    logic [3:0]         wr_strobe;
    logic [IMEM_AW-1:0] wr_addr;
    logic [31:0]        wr_data;

    // processor pins onto its bus port
    assign cpu_bus.req   = cpu_req_i;
    assign cpu_bus.write = cpu_write_i;
    assign cpu_bus.addr  = cpu_addr_i;
    assign cpu_bus.wdata = cpu_wdata_i;
    assign cpu_rdata_o   = cpu_bus.rdata;
    assign cpu_ack_o     = cpu_bus.ack;

    bootloader #(
        .IMEM_AW (IMEM_AW)
    ) i_bootloader (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (boot_bus.master),
        .wr_strobe_o (wr_strobe),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data),
        .boot_done_o (boot_done_o)
    );

    bus_arbiter i_bus_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .boot_bus  (boot_bus.slave),
        .cpu_bus   (cpu_bus.slave),
        .slave_bus (slave_bus.master)
    );

    spart #(
        .RX_FIFO_DEPTH (RX_FIFO_DEPTH)
    ) i_spart (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (slave_bus.slave),
        .rx_valid_i (rx_valid_i),
        .rx_byte_i  (rx_byte_i),
        .tx_valid_o (tx_valid_o),
        .tx_byte_o  (tx_byte_o)
    );

    imem #(
        .IMEM_AW (IMEM_AW)
    ) i_imem (
        .clk          (clk),
        .wr_strobe_i  (wr_strobe),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (wr_data),
        .fetch_addr_i (fetch_addr_i),
        .fetch_data_o (fetch_data_o)
    );

endmodule

//--- hdl/bootloader.sv
`timescale 1ns/1ps

module bootloader import boot_pkg::*; #(
    parameter int IMEM_AW = 14
) (
    input  logic               clk,
    input  logic               rst_n,
    sys_bus_if.master          bus,
    output logic [3:0]         wr_strobe_o,
    output logic [IMEM_AW-1:0] wr_addr_o,
    output logic [31:0]        wr_data_o,
    output logic               boot_done_o
);

    boot_state_t        state;
    boot_state_t        state_nxt;
    logic               req_q;
    logic [1:0]         byte_cnt;    // byte within count or word
    logic [31:0]        count_q;     // number of instructions to load
    logic [31:0]        instr_cnt;   // instructions written so far
    logic [23:0]        word_buf;    // lower three bytes of current word
    logic [IMEM_AW-1:0] addr_q;
    logic [7:0]         rx_byte;
    logic               rx_ack;
    logic               last_byte;
    logic               word_done;
    logic [31:0]        count_full;

    assign rx_byte    = bus.rdata[7:0];
    assign last_byte  = (byte_cnt == 2'd3);
    assign rx_ack     = bus.ack && ((state == BOOT_COUNT) || (state == BOOT_LOAD));
    assign word_done  = bus.ack && (state == BOOT_LOAD) && last_byte;
    // count as it stands once the top byte arrives
    assign count_full = {rx_byte, count_q[23:0]};

    // bus side, only the banner is a write
    assign bus.req   = req_q;
    assign bus.write = (state == BOOT_BANNER);
    assign bus.addr  = (state == BOOT_BANNER) ? SPART_TX_ADDR : SPART_RX_ADDR;
    assign bus.wdata = BUS_DW'(BANNER_CHAR);

    // imem write in the same cycle as the fourth byte
    assign wr_strobe_o = word_done ? 4'hf : 4'h0;
    assign wr_addr_o   = addr_q;
    assign wr_data_o   = {rx_byte, word_buf};

    assign boot_done_o = (state == BOOT_DONE);

    always_comb begin
        state_nxt = state;
        case (state)
            BOOT_BANNER: begin
                if (bus.ack) begin
                    state_nxt = BOOT_COUNT;
                end
            end
            BOOT_COUNT: begin
                if (bus.ack && last_byte) begin
                    // empty image finishes right away
                    state_nxt = (count_full == 32'd0) ? BOOT_DONE : BOOT_LOAD;
                end
            end
            BOOT_LOAD: begin
                if (word_done && (instr_cnt + 32'd1 == count_q)) begin
                    state_nxt = BOOT_DONE;
                end
            end
            default: begin
                state_nxt = BOOT_DONE;  // stays here until reset
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= BOOT_BANNER;
            req_q     <= 1'b0;
            byte_cnt  <= 2'd0;
            count_q   <= 32'd0;
            instr_cnt <= 32'd0;
            addr_q    <= '0;
        end else begin
            state <= state_nxt;
            req_q <= (state_nxt != BOOT_DONE);  // back to back requests
            if (rx_ack) begin
                byte_cnt <= byte_cnt + 2'd1;    // wraps after four bytes
            end
            if (bus.ack && (state == BOOT_COUNT)) begin
                count_q[8*byte_cnt +: 8] <= rx_byte;  // low byte first
            end
            if (word_done) begin
                instr_cnt <= instr_cnt + 32'd1;
                addr_q    <= addr_q + 1'b1;
            end
        end
    end

    // partial word, bytes 0 to 2
    always_ff @(posedge clk) begin
        if (bus.ack && (state == BOOT_LOAD)) begin
            case (byte_cnt)
                2'd0: word_buf[7:0]   <= rx_byte;
                2'd1: word_buf[15:8]  <= rx_byte;
                2'd2: word_buf[23:16] <= rx_byte;
                default: ;  // top byte goes straight to imem
            endcase
        end
    end

endmodule

//--- hdl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import boot_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    sys_bus_if.slave  boot_bus,
    sys_bus_if.slave  cpu_bus,
    sys_bus_if.master slave_bus
);

    logic grant_cpu;    // 0 while the bootloader owns the bus
    logic granted_req;
    logic xfer_open;

    assign granted_req = grant_cpu ? cpu_bus.req : boot_bus.req;

    // a transfer is open from req until its ack
    assign xfer_open = granted_req && !slave_bus.ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_cpu <= 1'b0;
        end else if (!xfer_open) begin
            // fixed priority, bootloader first
            if (boot_bus.req) begin
                grant_cpu <= 1'b0;
            end else if (cpu_bus.req) begin
                grant_cpu <= 1'b1;
            end
        end
    end

    // granted master onto the slave
    assign slave_bus.req   = granted_req;
    assign slave_bus.write = grant_cpu ? cpu_bus.write : boot_bus.write;
    assign slave_bus.addr  = grant_cpu ? cpu_bus.addr  : boot_bus.addr;
    assign slave_bus.wdata = grant_cpu ? cpu_bus.wdata : boot_bus.wdata;

    // response only to the owner
    assign boot_bus.ack   = !grant_cpu && slave_bus.ack;
    assign cpu_bus.ack    = grant_cpu && slave_bus.ack;
    assign boot_bus.rdata = grant_cpu ? {BUS_DW{1'b0}} : slave_bus.rdata;
    assign cpu_bus.rdata  = grant_cpu ? slave_bus.rdata : {BUS_DW{1'b0}};

endmodule

//--- hdl/imem.sv
`timescale 1ns/1ps

module imem #(
    parameter int IMEM_AW = 14
) (
    input  logic               clk,
    input  logic [3:0]         wr_strobe_i,
    input  logic [IMEM_AW-1:0] wr_addr_i,
    input  logic [31:0]        wr_data_i,
    input  logic [IMEM_AW-1:0] fetch_addr_i,
    output logic [31:0]        fetch_data_o
);

    logic [31:0] mem [2**IMEM_AW];

    // byte lane writes
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_strobe_i[i]) begin
                mem[wr_addr_i][8*i +: 8] <= wr_data_i[8*i +: 8];
            end
        end
    end

    // fetch data one cycle after the address
    always_ff @(posedge clk) begin
        fetch_data_o <= mem[fetch_addr_i];
    end

endmodule

//--- hdl/spart.sv
`timescale 1ns/1ps

module spart import boot_pkg::*; #(
    parameter int RX_FIFO_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    sys_bus_if.slave   bus,
    input  logic       rx_valid_i,
    input  logic [7:0] rx_byte_i,
    output logic       tx_valid_o,
    output logic [7:0] tx_byte_o
);

    localparam int PW = (RX_FIFO_DEPTH > 1) ? $clog2(RX_FIFO_DEPTH) : 1;
    localparam int CW = $clog2(RX_FIFO_DEPTH + 1);
    localparam logic [PW-1:0] LAST_PTR = PW'(RX_FIFO_DEPTH - 1);
    localparam logic [CW-1:0] FULL_CNT = CW'(RX_FIFO_DEPTH);

    logic [7:0]        rx_mem [RX_FIFO_DEPTH];
    logic [PW-1:0]     wr_ptr;
    logic [PW-1:0]     rd_ptr;
    logic [CW-1:0]     fifo_cnt;
    logic              fifo_empty;
    logic              fifo_full;
    logic              sel_tx;
    logic              sel_rx;
    logic              ack_q;
    logic              ack_nxt;
    logic              push;
    logic              pop;
    logic              tx_wr;
    logic [BUS_DW-1:0] rdata_q;

    assign fifo_empty = (fifo_cnt == '0);
    assign fifo_full  = (fifo_cnt == FULL_CNT);
    assign sel_tx     = (bus.addr == SPART_TX_ADDR);
    assign sel_rx     = (bus.addr == SPART_RX_ADDR);

    // new request once the previous ack is gone
    // rx reads stall while the fifo is empty
    assign ack_nxt = bus.req && !ack_q && (bus.write || !sel_rx || !fifo_empty);
    assign pop     = ack_nxt && !bus.write && sel_rx;
    assign tx_wr   = ack_nxt && bus.write && sel_tx;
    assign push    = rx_valid_i && !fifo_full;  // drop when full

    always_ff @(posedge clk) begin
        if (push) begin
            rx_mem[wr_ptr] <= rx_byte_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q      <= 1'b0;
            tx_valid_o <= 1'b0;
        end else begin
            ack_q      <= ack_nxt;
            tx_valid_o <= tx_wr;  // lines up with ack
        end
    end

    always_ff @(posedge clk) begin
        if (ack_nxt) begin
            rdata_q <= pop ? BUS_DW'(rx_mem[rd_ptr]) : '0;  // unmapped reads give zero
        end
        if (tx_wr) begin
            tx_byte_o <= bus.wdata[7:0];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

endmodule

//--- hdl/sys_bus_if.sv
`timescale 1ns/1ps

interface sys_bus_if import boot_pkg::*; ();

    logic              req;    // held by master until ack
    logic              write;
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] wdata;
    logic [BUS_DW-1:0] rdata;  // only valid with ack
    logic              ack;    // one cycle pulse from slave

    modport master (
        output req,
        output write,
        output addr,
        output wdata,
        input  rdata,
        input  ack
    );

    modport slave (
        input  req,
        input  write,
        input  addr,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

//--- verif/boot_checker.sv
`timescale 1ns/1ps

module boot_checker import boot_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       tx_valid_i,
    input logic [7:0] tx_byte_i,
    input logic       boot_done_i,
    input logic       cpu_ack_i
);

    string      test_name;
    int         test_errs;
    int         n_pass;
    int         n_fail;
    logic [7:0] tx_q [$];   // tx bytes seen since the test began
    bit         block_watch;

    initial begin
        test_name   = "none";
        test_errs   = 0;
        n_pass      = 0;
        n_fail      = 0;
        block_watch = 1'b0;
    end

    always @(posedge clk) begin
        if (rst_n && tx_valid_i) begin
            tx_q.push_back(tx_byte_i);
        end
        // processor must stay stalled until boot is over
        if (block_watch && cpu_ack_i && !boot_done_i) begin
            report_failure("processor acknowledged before boot done");
        end
    end

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
        tx_q.delete();
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic report_failure(input string msg);
        boot_state_t st;
        st = tb_boot.i_dut.i_bootloader.state;
        $display("Failure in %s: %s (bootloader state %s)", test_name, msg, st.name());
        test_errs++;
    endtask

    // exactly one tx byte during boot, the banner
    task automatic check_banner();
        check_value("tx byte count", 32'd1, tx_q.size());
        if (tx_q.size() > 0) begin
            check_value("banner", {24'd0, BANNER_CHAR}, {24'd0, tx_q[0]});
        end
    endtask

    task automatic check_tx_last(input logic [7:0] exp);
        if (tx_q.size() == 0) begin
            report_failure("no byte left the serial port");
        end else begin
            check_value("tx byte", {24'd0, exp}, {24'd0, tx_q[$]});
        end
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
            n_pass++;
        end else begin
            $display("test %s: FAILED with %0d errors", test_name, test_errs);
            n_fail++;
        end
    endtask

    task automatic print_counts();
        $display("tests run %0d, ok %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
    endtask

endmodule

//--- verif/boot_vectors.txt
# test <name> <count> <max gap> <cpu ops> <first op raised during boot>
# then <count> hex words, then ops: <w|r> <addr> <wdata> <expected tx byte or rdata>
test image_load 4 0 0 0
deadbeef
01234567
89abcdef
a5a55a5a
test back_pressure 6 20 0 0
11223344
55667788
99aabbcc
ddeeff00
0badf00d
cafebabe
test zero_count 0 0 0 0
test cpu_after_boot 2 0 2 0
13579bdf
2468ace0
w 1c 00000061 00000061
r 40 00000000 00000000
test cpu_blocked 3 5 2 1
fedcba98
76543210
c0ffee11
w 1c 0000005a 0000005a
r 1c 00000000 00000000

//--- verif/tb_boot.sv
`timescale 1ns/1ps

module tb_boot import boot_pkg::*; ();

    localparam int IMEM_AW = 14;
    localparam int LIMIT   = 2000;  // cycles per wait

    logic               clk;
    logic               rst_n;
    logic               rx_valid_i;
    logic [7:0]         rx_byte_i;
    logic               tx_valid_o;
    logic [7:0]         tx_byte_o;
    logic               cpu_req_i;
    logic               cpu_write_i;
    logic [BUS_AW-1:0]  cpu_addr_i;
    logic [BUS_DW-1:0]  cpu_wdata_i;
    logic [BUS_DW-1:0]  cpu_rdata_o;
    logic               cpu_ack_o;
    logic [IMEM_AW-1:0] fetch_addr_i;
    logic [31:0]        fetch_data_o;
    logic               boot_done_o;

    int          fd;
    bit          file_ok;
    string       line;
    string       name;
    int          count;
    int          gap_max;
    int          n_ops;
    int          early;
    logic [31:0] words [64];
    string       op_kind [4];
    logic [31:0] op_addr [4];
    logic [31:0] op_wdata [4];
    logic [31:0] op_exp [4];
    logic [31:0] prev_word0;

    boot_top #(.IMEM_AW(IMEM_AW), .RX_FIFO_DEPTH(8)) i_dut (.*);

    boot_checker i_chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_valid_i  (tx_valid_o),
        .tx_byte_i   (tx_byte_o),
        .boot_done_i (boot_done_o),
        .cpu_ack_i   (cpu_ack_o)
    );

    always #4 clk = ~clk;

    // skips comment and blank lines
    task automatic next_line(output bit ok);
        ok = 1'b0;
        while (!ok && !$feof(fd)) begin
            if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic apply_reset();
        rst_n       = 1'b0;
        rx_valid_i  = 1'b0;
        rx_byte_i   = 8'h00;
        cpu_req_i   = 1'b0;
        cpu_write_i = 1'b0;
        cpu_addr_i  = '0;
        cpu_wdata_i = '0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = (gap_max == 0) ? 0 : int'($urandom % (gap_max + 1));
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        i_chk.check_value("done before last byte", 32'd0, {31'd0, boot_done_o});
        rx_valid_i = 1'b1;
        rx_byte_i  = b;
        @(posedge clk);
        #1 rx_valid_i = 1'b0;
        @(posedge clk);  // one idle cycle keeps the fifo shallow
        #1;
    endtask

    task automatic wait_done();
        int i;
        for (i = 0; i < LIMIT && !boot_done_o; i++) begin
            @(posedge clk);
            #1;
        end
        if (!boot_done_o) i_chk.report_failure("boot done never rose");
    endtask

    task automatic start_cpu(input int k);
        cpu_req_i   = 1'b1;
        cpu_write_i = (op_kind[k] == "w");
        cpu_addr_i  = op_addr[k];
        cpu_wdata_i = op_wdata[k];
    endtask

    task automatic finish_cpu(input int k);
        int i;
        for (i = 0; i < LIMIT && !cpu_ack_o; i++) begin
            @(posedge clk);
            #1;
        end
        if (!cpu_ack_o) begin
            i_chk.report_failure("processor request never acknowledged");
        end else if (op_kind[k] != "w") begin
            i_chk.check_value("cpu read", op_exp[k], cpu_rdata_o);
        end
        cpu_req_i = 1'b0;
        @(posedge clk);
        #1;
        if (op_kind[k] == "w") i_chk.check_tx_last(op_exp[k][7:0]);
    endtask

    task automatic fetch_check(input int a, input logic [31:0] exp);
        fetch_addr_i = a[IMEM_AW-1:0];
        @(posedge clk);
        #1 i_chk.check_value($sformatf("imem[%0d]", a), exp, fetch_data_o);
    endtask

    task automatic run_test();
        i_chk.begin_test(name);
        apply_reset();
        if (early != 0) begin
            repeat (2) @(posedge clk);  // bootloader owns the bus by now
            #1 start_cpu(0);
            i_chk.block_watch = 1'b1;
        end
        for (int b = 0; b < 4; b++) send_byte(count[8*b +: 8]);
        for (int w = 0; w < count; w++) begin
            for (int b = 0; b < 4; b++) send_byte(words[w][8*b +: 8]);
        end
        wait_done();
        i_chk.check_banner();
        if (early != 0) begin
            finish_cpu(0);
            i_chk.block_watch = 1'b0;
        end
        for (int w = 0; w < count; w++) fetch_check(w, words[w]);
        if (count == 0) fetch_check(0, prev_word0);  // left from the last image
        else prev_word0 = words[0];
        for (int k = early; k < n_ops; k++) begin
            start_cpu(k);
            finish_cpu(k);
        end
        i_chk.end_test();
    endtask

    initial begin
        bit ok;
        clk          = 1'b0;
        fetch_addr_i = '0;
        prev_word0   = 32'hx;
        file_ok      = 1'b1;
        void'($urandom(32'h04fc_dda3));
        apply_reset();
        fd = $fopen("verif/boot_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/boot_vectors.txt");
            file_ok = 1'b0;
        end else begin
            next_line(ok);
            while (ok) begin
                void'($sscanf(line, "test %s %d %d %d %d", name, count, gap_max,
                              n_ops, early));
                for (int w = 0; w < count; w++) begin
                    next_line(ok);
                    void'($sscanf(line, "%h", words[w]));
                end
                for (int k = 0; k < n_ops; k++) begin
                    next_line(ok);
                    void'($sscanf(line, "%s %h %h %h", op_kind[k], op_addr[k],
                                  op_wdata[k], op_exp[k]));
                end
                run_test();
                next_line(ok);
            end
            $fclose(fd);
        end
        i_chk.print_counts();
        if (file_ok && i_chk.n_fail == 0 && i_chk.n_pass > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
hdl/boot_pkg.sv
hdl/sys_bus_if.sv
hdl/bootloader.sv
hdl/bus_arbiter.sv
hdl/spart.sv
hdl/imem.sv
hdl/boot_top.sv
verif/boot_checker.sv
verif/tb_boot.sv
